// ==== router_stats_regs.f ====
+incdir+hw
hw/router_stats_pkg.sv
hw/drop_event_counter.sv
hw/counter_snapshot.sv
hw/reg_access_fsm.sv
hw/router_stats_regs.sv
tests/router_stats_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the router statistics testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f router_stats_regs.f \
    --top-module router_stats_tb \
    -Mdir obj_dir \
    && ./obj_dir/Vrouter_stats_tb \
    || { echo "Simulation failed"; exit 1; }

// ==== tests/router_stats_tb.sv ====
/* Router statistics testbench */
`default_nettype none

`include "router_stats_defines.svh"

module router_stats_tb
    import router_stats_pkg::*;
();

    localparam int    TIMEOUT_CYCLES = 4000;
    localparam word_t ALL_PORTS      = word_t'(port_mask_t'('1));

    logic        core_clk_ifc = 1'b0;
    logic        peripheral_sresetn_core;
    logic        req_valid;
    logic        req_write;
    reg_addr_t   req_addr;
    word_t       req_wdata;
    port_mask_t  ports_connected;
    port_mask_t  async_fifo_overflow;
    port_mask_t  buf_overflow;
    logic        rsp_valid;
    logic        rsp_error;
    word_t       rsp_rdata;
    logic        credit_return;
    port_mask_t  port_enable;

    // Host bookkeeping with expected responses in a ring indexed by request number
    int          issued_n   = 0;
    int          returned_n = 0;
    int          credit_n   = 0;
    int          credits;
    int          cycle_n    = 0;
    logic [7:0]  head;
    logic        exp_err  [256];
    word_t       exp_data [256];
    string       exp_name [256];
    string       test_name = "reset_values";
    logic [31:0] rng = 32'd11099;

    // Shadow copy of the register block
    port_mask_t  sh_en       = '1;
    port_mask_t  sh_sample   = '0;
    logic [7:0]  sh_sel_port = '0;
    logic [7:0]  sh_sel_cntr = '0;
    cnt_t        sh_live [`RS_NUM_PORTS][`RS_CNTRS_PER_PORT];
    cnt_t        sh_snap [`RS_NUM_PORTS][`RS_CNTRS_PER_PORT];

    always #4 core_clk_ifc = ~core_clk_ifc;

    router_stats_regs i_dut (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .req_valid               ( req_valid               ),
        .req_write               ( req_write               ),
        .req_addr                ( req_addr                ),
        .req_wdata               ( req_wdata               ),
        .ports_connected         ( ports_connected         ),
        .async_fifo_overflow     ( async_fifo_overflow     ),
        .buf_overflow            ( buf_overflow            ),
        .rsp_valid               ( rsp_valid               ),
        .rsp_error               ( rsp_error               ),
        .rsp_rdata               ( rsp_rdata               ),
        .credit_return           ( credit_return           ),
        .port_enable             ( port_enable             )
    );

    // Every port reports itself connected exactly when enabled
    assign ports_connected = port_enable;
    assign head            = returned_n[7:0];
    assign credits         = `RS_REQ_CREDITS - (issued_n - credit_n);

    always @(posedge core_clk_ifc) begin
        if (rsp_valid) begin
            returned_n <= returned_n + 1;
        end
        if (credit_return) begin
            credit_n <= credit_n + 1;
        end
    end

    always @(posedge core_clk_ifc) begin
        cycle_n <= cycle_n + 1;
        if (cycle_n >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    //////////////////////////////////////////////////
    // Helpers

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        abort_run();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] draw_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Register rules applied in request order
    task automatic model_access(input logic wr, input reg_addr_t addr, input word_t wdata,
                                output logic err, output word_t data);
        port_mask_t rise;
        err  = (addr >= `RS_NUM_REGS);
        data = '0;
        rise = '0;
        if (wr) begin
            case (addr)
                `RS_ADDR_PORT_EN_CON: sh_en = port_mask_t'(wdata);
                `RS_ADDR_SAMPLE_CON: begin
                    rise      = port_mask_t'(wdata) & ~sh_sample;
                    sh_sample = port_mask_t'(wdata);
                end
                `RS_ADDR_READ_SEL: begin
                    sh_sel_port = wdata[15:8];
                    sh_sel_cntr = wdata[7:0];
                end
                default: ;
            endcase
        end else begin
            case (addr)
                `RS_ADDR_PARAMS:       data = (word_t'(`RS_MTU_BYTES) << 16) | word_t'(`RS_NUM_PORTS);
                `RS_ADDR_PORT_EN_CON:  data = word_t'(sh_en);
                `RS_ADDR_PORT_EN_STAT: data = word_t'(sh_en);
                `RS_ADDR_SAMPLE_CON:   data = word_t'(sh_sample);
                `RS_ADDR_READ_SEL:     data = {16'h0000, sh_sel_port, sh_sel_cntr};
                `RS_ADDR_READ_DATA: begin
                    // Out of range selects match nothing and read 0
                    for (int p = 0; p < `RS_NUM_PORTS; p++) begin
                        for (int c = 0; c < `RS_CNTRS_PER_PORT; c++) begin
                            if (sh_sel_port == 8'(p) && sh_sel_cntr == 8'(c)) begin
                                data = word_t'(sh_snap[p][c]);
                            end
                        end
                    end
                end
                default: data = '0;
            endcase
        end
        // Sampled ports take their live counts and restart from zero
        for (int p = 0; p < `RS_NUM_PORTS; p++) begin
            for (int c = 0; c < `RS_CNTRS_PER_PORT; c++) begin
                if (rise[p]) begin
                    sh_snap[p][c] = sh_live[p][c];
                    sh_live[p][c] = '0;
                end
            end
        end
    endtask

    // Sends one request as soon as a credit is held
    task automatic issue_request(input logic wr, input reg_addr_t addr, input word_t wdata);
        logic  err;
        word_t data;
        while (credits == 0) begin
            @(negedge core_clk_ifc);
        end
        model_access(wr, addr, wdata, err, data);
        exp_err[issued_n[7:0]]  = err;
        exp_data[issued_n[7:0]] = data;
        exp_name[issued_n[7:0]] = test_name;
        issued_n  = issued_n + 1;
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        @(negedge core_clk_ifc);
        req_valid = 1'b0;
    endtask

    // Waits for the last response plus one quiet cycle
    task automatic wait_idle();
        while (issued_n != returned_n) begin
            @(negedge core_clk_ifc);
        end
        @(negedge core_clk_ifc);
    endtask

    task automatic pulse_events(input port_mask_t fifo_mask, input port_mask_t buf_mask);
        wait_idle();
        async_fifo_overflow = fifo_mask;
        buf_overflow        = buf_mask;
        for (int p = 0; p < `RS_NUM_PORTS; p++) begin
            sh_live[p][0] = sh_live[p][0] + cnt_t'(fifo_mask[p]);
            sh_live[p][1] = sh_live[p][1] + cnt_t'(buf_mask[p]);
        end
        @(negedge core_clk_ifc);
        async_fifo_overflow = '0;
        buf_overflow        = '0;
        @(negedge core_clk_ifc);
    endtask

    task automatic read_snapshots();
        for (int p = 0; p < `RS_NUM_PORTS; p++) begin
            for (int c = 0; c < `RS_CNTRS_PER_PORT; c++) begin
                issue_request(1'b1, `RS_ADDR_READ_SEL, {16'h0000, 8'(p), 8'(c)});
                issue_request(1'b0, `RS_ADDR_READ_DATA, '0);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Checks

    a_rsp_error: assert property (
        @(negedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp_valid |-> rsp_error == exp_err[head]
    ) else report_mismatch({exp_name[head], " error"}, word_t'(exp_err[head]),
                           word_t'(rsp_error));

    a_rsp_data: assert property (
        @(negedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp_valid |-> rsp_rdata == exp_data[head]
    ) else report_mismatch({exp_name[head], " rdata"}, exp_data[head], rsp_rdata);

    a_credit_on_rsp: assert property (
        @(negedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp_valid |-> credit_return
    ) else begin
        $display("A response arrived without its credit return");
        abort_run();
    end

    a_credit_range: assert property (
        @(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        credits >= 0 && credits <= `RS_REQ_CREDITS
    ) else begin
        $display("Host credit count left its range, now %0d", credits);
        abort_run();
    end

    // With nothing in flight every enable write has landed
    a_port_enable: assert property (
        @(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        issued_n == returned_n |-> port_enable == sh_en
    ) else report_mismatch({test_name, " port_enable"}, word_t'(sh_en), word_t'(port_enable));

    //////////////////////////////////////////////////
    // Stimulus

    initial begin
        port_mask_t  fm;
        port_mask_t  bm;
        logic [31:0] rnd;
        peripheral_sresetn_core = 1'b0;
        req_valid               = 1'b0;
        req_write               = 1'b0;
        req_addr                = '0;
        req_wdata               = '0;
        async_fifo_overflow     = '0;
        buf_overflow            = '0;
        sh_live                 = '{default: '0};
        sh_snap                 = '{default: '0};
        repeat (8) @(negedge core_clk_ifc);
        peripheral_sresetn_core = 1'b1;

        for (int a = 0; a <= int'(`RS_ADDR_READ_SEL); a++) begin
            issue_request(1'b0, reg_addr_t'(a), '0);
        end

        test_name = "port_enables";
        repeat (6) begin
            issue_request(1'b1, `RS_ADDR_PORT_EN_CON, word_t'(port_mask_t'(draw_random())));
            wait_idle();
            issue_request(1'b0, `RS_ADDR_PORT_EN_CON, '0);
            issue_request(1'b0, `RS_ADDR_PORT_EN_STAT, '0);
        end

        // Port p sees p+1 FIFO pulses and 2p+1 buffer pulses
        test_name = "drop_counting";
        for (int k = 0; k < 2 * `RS_NUM_PORTS - 1; k++) begin
            for (int p = 0; p < `RS_NUM_PORTS; p++) begin
                fm[p] = (k < p + 1);
                bm[p] = (k < 2 * p + 1);
            end
            pulse_events(fm, bm);
        end
        issue_request(1'b1, `RS_ADDR_SAMPLE_CON, ALL_PORTS);
        read_snapshots();
        issue_request(1'b1, `RS_ADDR_SAMPLE_CON, '0);
        issue_request(1'b1, `RS_ADDR_SAMPLE_CON, ALL_PORTS);
        read_snapshots();

        test_name = "partial_sampling";
        issue_request(1'b1, `RS_ADDR_SAMPLE_CON, '0);
        repeat (3) pulse_events(port_mask_t'(draw_random()), port_mask_t'(draw_random()));
        issue_request(1'b1, `RS_ADDR_SAMPLE_CON, word_t'(port_mask_t'(draw_random())));
        read_snapshots();
        pulse_events(port_mask_t'(draw_random()), port_mask_t'(draw_random()));
        issue_request(1'b1, `RS_ADDR_SAMPLE_CON, '0);
        issue_request(1'b1, `RS_ADDR_SAMPLE_CON, ALL_PORTS);
        read_snapshots();

        test_name = "invalid_access";
        issue_request(1'b0, reg_addr_t'(`RS_NUM_REGS), '0);
        issue_request(1'b0, reg_addr_t'(`RS_NUM_REGS + draw_random() % 250), '0);
        issue_request(1'b1, reg_addr_t'(8'hff), draw_random());
        issue_request(1'b1, `RS_ADDR_PARAMS, draw_random());
        issue_request(1'b0, `RS_ADDR_PARAMS, '0);
        // Nonzero snapshots everywhere, so a wrapped select would read a real count
        pulse_events('1, '1);
        issue_request(1'b1, `RS_ADDR_SAMPLE_CON, '0);
        issue_request(1'b1, `RS_ADDR_SAMPLE_CON, ALL_PORTS);
        issue_request(1'b1, `RS_ADDR_READ_SEL, {16'h0000, 8'(`RS_NUM_PORTS), 8'h00});
        issue_request(1'b0, `RS_ADDR_READ_DATA, '0);
        issue_request(1'b1, `RS_ADDR_READ_SEL, {16'h0000, 8'h00, 8'(`RS_CNTRS_PER_PORT)});
        issue_request(1'b0, `RS_ADDR_READ_DATA, '0);
        issue_request(1'b0, `RS_ADDR_READ_SEL, '0);

        // Mixed traffic on every cycle a credit is held
        test_name = "credit_flow";
        repeat (24) begin
            rnd = draw_random();
            issue_request(rnd[8], reg_addr_t'(rnd[2:0]), rnd >> 12);
        end
        wait_idle();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/router_stats_regs.sv ====
/* Router ingress statistics registers */
`default_nettype none

`include "router_stats_defines.svh"

module router_stats_regs
    import router_stats_pkg::*;
(
    input  wire logic       core_clk_ifc,
    input  wire logic       peripheral_sresetn_core,
    input  wire logic       req_valid,
    input  wire logic       req_write,
    input  wire reg_addr_t  req_addr,
    input  wire word_t      req_wdata,
    input  wire port_mask_t ports_connected,
    input  wire port_mask_t async_fifo_overflow,
    input  wire port_mask_t buf_overflow,
    output logic            rsp_valid,
    output logic            rsp_error,
    output word_t           rsp_rdata,
    output logic            credit_return,
    output port_mask_t      port_enable
);

    port_mask_t sample_pulse;
    logic [7:0] sel_port;
    logic [7:0] sel_cntr;
    cnt_t       sel_data;
    cnt_t       fifo_ovf_cnt [`RS_NUM_PORTS];
    cnt_t       buf_ovf_cnt  [`RS_NUM_PORTS];

    //////////////////////////////////////////////////
    // Host side

    reg_access_fsm i_fsm (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .req_valid               ( req_valid               ),
        .req_write               ( req_write               ),
        .req_addr                ( req_addr                ),
        .req_wdata               ( req_wdata               ),
        .ports_connected         ( ports_connected         ),
        .sel_data                ( sel_data                ),
        .rsp_valid               ( rsp_valid               ),
        .rsp_error               ( rsp_error               ),
        .rsp_rdata               ( rsp_rdata               ),
        .credit_return           ( credit_return           ),
        .port_enable             ( port_enable             ),
        .sample_pulse            ( sample_pulse            ),
        .sel_port                ( sel_port                ),
        .sel_cntr                ( sel_cntr                )
    );

    //////////////////////////////////////////////////
    // Drop counters and snapshots

    for (genvar p = 0; p < `RS_NUM_PORTS; p++) begin : g_port
        drop_event_counter i_fifo_ovf (
            .core_clk_ifc            ( core_clk_ifc            ),
            .peripheral_sresetn_core ( peripheral_sresetn_core ),
            .event_in                ( async_fifo_overflow[p]  ),
            .sample                  ( sample_pulse[p]         ),
            .count                   ( fifo_ovf_cnt[p]         )
        );

        drop_event_counter i_buf_ovf (
            .core_clk_ifc            ( core_clk_ifc            ),
            .peripheral_sresetn_core ( peripheral_sresetn_core ),
            .event_in                ( buf_overflow[p]         ),
            .sample                  ( sample_pulse[p]         ),
            .count                   ( buf_ovf_cnt[p]          )
        );
    end

    counter_snapshot i_snapshot (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample_pulse            ( sample_pulse            ),
        .fifo_ovf_cnt            ( fifo_ovf_cnt            ),
        .buf_ovf_cnt             ( buf_ovf_cnt             ),
        .sel_port                ( sel_port                ),
        .sel_cntr                ( sel_cntr                ),
        .sel_data                ( sel_data                )
    );

endmodule

`default_nettype wire

// ==== hw/reg_access_fsm.sv ====
/* Register access FSM */
`default_nettype none

`include "router_stats_defines.svh"

module reg_access_fsm
    import router_stats_pkg::*;
(
    input  wire logic       core_clk_ifc,
    input  wire logic       peripheral_sresetn_core,
    input  wire logic       req_valid,
    input  wire logic       req_write,
    input  wire reg_addr_t  req_addr,
    input  wire word_t      req_wdata,
    input  wire port_mask_t ports_connected,
    input  wire cnt_t       sel_data,
    output logic            rsp_valid,
    output logic            rsp_error,
    output word_t           rsp_rdata,
    output logic            credit_return,
    output port_mask_t      port_enable,
    output port_mask_t      sample_pulse,
    output logic [7:0]      sel_port,
    output logic [7:0]      sel_cntr
);

    localparam int QPTR_W = $clog2(`RS_REQ_CREDITS);
    localparam int QCNT_W = $clog2(`RS_REQ_CREDITS + 1);
    localparam word_t PARAMS_WORD = {16'(`RS_MTU_BYTES), 8'h00, 8'(`RS_NUM_PORTS)};

    logic              q_write [`RS_REQ_CREDITS];
    reg_addr_t         q_addr  [`RS_REQ_CREDITS];
    word_t             q_wdata [`RS_REQ_CREDITS];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] q_count;
    logic              q_empty;
    logic              take;
    logic              push;
    logic              pop;

    access_state_t state;
    logic          cur_write;
    reg_addr_t     cur_addr;
    word_t         cur_wdata;
    word_t         dec_rdata;
    logic          dec_error;
    logic          credit_q;
    port_mask_t    sample_con;
    port_mask_t    sample_con_d;
    port_mask_t    port_en_stat;

    //////////////////////////////////////////////////
    // Request queue

    assign q_empty = (q_count == '0);
    // An idle FSM takes the queue head, or the incoming request when empty
    assign take = (state == IDLE) && (!q_empty || req_valid);
    assign pop  = take && !q_empty;
    assign push = req_valid && !(take && q_empty);

    always_ff @(posedge core_clk_ifc) begin
        if (push) begin
            q_write[wr_ptr] <= req_write;
            q_addr[wr_ptr]  <= req_addr;
            q_wdata[wr_ptr] <= req_wdata;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(`RS_REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(`RS_REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            q_count <= q_count + QCNT_W'(push) - QCNT_W'(pop);
        end
    end

    //////////////////////////////////////////////////
    // Access FSM

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            state    <= IDLE;
            credit_q <= 1'b0;
        end else begin
            credit_q <= (state == DECODE);
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= DECODE;
                    end
                end
                DECODE:  state <= RESPOND;
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Request being served
    always_ff @(posedge core_clk_ifc) begin
        if (take) begin
            cur_write <= q_empty ? req_write : q_write[rd_ptr];
            cur_addr  <= q_empty ? req_addr  : q_addr[rd_ptr];
            cur_wdata <= q_empty ? req_wdata : q_wdata[rd_ptr];
        end
    end

    always_comb begin
        dec_rdata = '0;
        dec_error = (cur_addr >= `RS_NUM_REGS);
        if (!cur_write) begin
            case (cur_addr)
                `RS_ADDR_PARAMS:       dec_rdata = PARAMS_WORD;
                `RS_ADDR_PORT_EN_CON:  dec_rdata = word_t'(port_enable);
                `RS_ADDR_PORT_EN_STAT: dec_rdata = word_t'(port_en_stat);
                `RS_ADDR_SAMPLE_CON:   dec_rdata = word_t'(sample_con);
                `RS_ADDR_READ_SEL:     dec_rdata = {16'h0000, sel_port, sel_cntr};
                `RS_ADDR_READ_DATA:    dec_rdata = word_t'(sel_data);
                default:               dec_rdata = '0;
            endcase
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (state == DECODE) begin
            rsp_rdata <= dec_rdata;
            rsp_error <= dec_error;
        end
    end

    assign rsp_valid     = (state == RESPOND);
    assign credit_return = credit_q;

    //////////////////////////////////////////////////
    // Control and status registers

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            port_enable  <= '1;
            sample_con   <= '0;
            sample_con_d <= '0;
            sel_port     <= '0;
            sel_cntr     <= '0;
            port_en_stat <= '0;
        end else begin
            sample_con_d <= sample_con;
            port_en_stat <= ports_connected;
            // Writes land on the response cycle
            if (state == RESPOND && cur_write) begin
                case (cur_addr)
                    `RS_ADDR_PORT_EN_CON: port_enable <= cur_wdata[`RS_NUM_PORTS-1:0];
                    `RS_ADDR_SAMPLE_CON:  sample_con  <= cur_wdata[`RS_NUM_PORTS-1:0];
                    `RS_ADDR_READ_SEL: begin
                        sel_port <= cur_wdata[15:8];
                        sel_cntr <= cur_wdata[7:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // One pulse per port on a 0 to 1 change
    assign sample_pulse = sample_con & ~sample_con_d;

    // Host must not send without a credit
    a_no_overrun: assert property (
        @(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        req_valid |-> q_count != QCNT_W'(`RS_REQ_CREDITS)
    );

    a_credit_with_rsp: assert property (
        @(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp_valid == credit_return
    );

endmodule

`default_nettype wire

// ==== hw/counter_snapshot.sv ====
/* Counter snapshot bank */
`default_nettype none

`include "router_stats_defines.svh"

module counter_snapshot
    import router_stats_pkg::*;
(
    input  wire logic       core_clk_ifc,
    input  wire logic       peripheral_sresetn_core,
    input  wire port_mask_t sample_pulse,
    input  wire cnt_t       fifo_ovf_cnt [`RS_NUM_PORTS],
    input  wire cnt_t       buf_ovf_cnt  [`RS_NUM_PORTS],
    input  wire logic [7:0] sel_port,
    input  wire logic [7:0] sel_cntr,
    output cnt_t            sel_data
);

    localparam int PORT_IDX_W = $clog2(`RS_NUM_PORTS);
    localparam int CNTR_IDX_W = $clog2(`RS_CNTRS_PER_PORT);

    cnt_t snap [`RS_NUM_PORTS][`RS_CNTRS_PER_PORT];
    logic sel_in_range;

    //////////////////////////////////////////////////
    // Snapshot registers

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            snap <= '{default: '0};
        end else begin
            for (int p = 0; p < `RS_NUM_PORTS; p++) begin
                if (sample_pulse[p]) begin
                    snap[p][0] <= fifo_ovf_cnt[p];
                    snap[p][1] <= buf_ovf_cnt[p];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Indirect read mux

    assign sel_in_range = (sel_port < `RS_NUM_PORTS) && (sel_cntr < `RS_CNTRS_PER_PORT);

    always_comb begin
        sel_data = '0;
        if (sel_in_range) begin
            sel_data = snap[sel_port[PORT_IDX_W-1:0]][sel_cntr[CNTR_IDX_W-1:0]];
        end
    end

    // A port's snapshot moves only on its own sample pulse
    for (genvar p = 0; p < `RS_NUM_PORTS; p++) begin : g_hold_chk
        a_snap_hold: assert property (
            @(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
            !sample_pulse[p] |=> $stable(snap[p][0]) && $stable(snap[p][1])
        );
    end

endmodule

`default_nettype wire

// ==== hw/drop_event_counter.sv ====
/* Drop event edge counter */
`default_nettype none

module drop_event_counter
    import router_stats_pkg::*;
(
    input  wire logic core_clk_ifc,
    input  wire logic peripheral_sresetn_core,
    input  wire logic event_in,
    input  wire logic sample,
    output cnt_t      count
);

    logic event_d;
    logic event_rise;

    // Rising edge against the previous cycle's level
    assign event_rise = event_in && !event_d;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            event_d <= 1'b0;
            count   <= '0;
        end else begin
            event_d <= event_in;
            if (sample) begin
                // Restart the count and keep an edge seen in this cycle
                count <= cnt_t'(event_rise);
            end else if (event_rise) begin
                count <= count + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks

    // Only a sample may take the count backwards
    a_count_monotonic: assert property (
        @(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        !sample |=> count >= $past(count)
    );

endmodule

`default_nettype wire

// ==== hw/router_stats_pkg.sv ====
/* Router statistics types */
`default_nettype none

`include "router_stats_defines.svh"

package router_stats_pkg;

    //////////////////////////////////////////////////
    // Vector types

    // One register word on the host bus
    typedef logic [31:0] word_t;

    // Word address, not a byte address
    typedef logic [7:0] reg_addr_t;

    typedef logic [`RS_NUM_PORTS-1:0] port_mask_t;

    typedef logic [`RS_CNT_W-1:0] cnt_t;

    //////////////////////////////////////////////////
    // Register access FSM

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        RESPOND
    } access_state_t;

endpackage

`default_nettype wire

// ==== hw/router_stats_defines.svh ====
/* Router statistics parameters */
`ifndef ROUTER_STATS_DEFINES_SVH
`define ROUTER_STATS_DEFINES_SVH

// Port and counter geometry
`define RS_NUM_PORTS          4
`define RS_CNT_W              32
// Counter 0 is async FIFO overflow, counter 1 is buffer overflow
`define RS_CNTRS_PER_PORT     2

// Reported in the parameter word
`define RS_MTU_BYTES          2000

// Request slots, same as the credits the host starts with
`define RS_REQ_CREDITS        2

// Word addresses
`define RS_ADDR_PARAMS        8'd0
`define RS_ADDR_PORT_EN_CON   8'd1
`define RS_ADDR_PORT_EN_STAT  8'd2
`define RS_ADDR_SAMPLE_CON    8'd3
`define RS_ADDR_READ_SEL      8'd4
`define RS_ADDR_READ_DATA     8'd5
`define RS_NUM_REGS           6

`endif
